// File: Bender.yml
package:
  name: dccm_ctl

sources:
  - files:
      - hdl/dccm_pkg.sv
      - hdl/dccm_access.sv
      - hdl/dccm_stbuf.sv
      - hdl/dccm_ram.sv
      - hdl/dccm_load_align.sv
      - hdl/dccm_ctl.sv
  - target: test
    files:
      - verif/tb_dccm_ctl.sv

// File: files.f
hdl/dccm_pkg.sv
hdl/dccm_access.sv
hdl/dccm_stbuf.sv
hdl/dccm_ram.sv
hdl/dccm_load_align.sv
hdl/dccm_ctl.sv
verif/tb_dccm_ctl.sv

// File: hdl/dccm_access.sv
// dccm access stage: wishbone classic slave, request build, read pulse, store push and acknowledge
`timescale 1ns/1ns
`default_nettype none

module dccm_access
   import dccm_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   // wishbone slave side
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  word_addr_t wb_adr,
   input  byteen_t    wb_sel,
   input  data_t      wb_dat_w,
   output logic       wb_ack,

   // store buffer and load path
   input  logic       stbuf_ready,
   output logic       push,
   output logic       rd_req,
   output lsu_req_t   req
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD_WAIT,
      ST_RESPOND
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   bus_req;
   logic   is_idle;
   logic   ack_nxt;

   assign bus_req = wb_cyc & wb_stb;
   assign is_idle = (state == ST_IDLE);

   // --------------------
   // request build
   // --------------------
   always_comb begin
      req.is_store  = wb_we;
      req.word_addr = wb_adr;
      req.byteen    = wb_sel;
      req.wdata     = wb_dat_w;
      req.offset    = 2'd0;
      // scan from the top so the lowest set lane is the last one written
      for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
         if (wb_sel[b]) begin
            req.offset = 2'(b);
         end
      end
   end

   // only an idle stage launches work, so one transfer gives one read or one push
   assign rd_req = is_idle & bus_req & ~wb_we;
   assign push   = is_idle & bus_req & wb_we & stbuf_ready;   // store waits here while full

   // --------------------
   // transfer FSM
   // --------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (rd_req) begin
               state_nxt = ST_LOAD_WAIT;                    // memory data comes next cycle
            end else if (push) begin
               state_nxt = ST_RESPOND;                      // store acked from the buffer
            end
         end
         ST_LOAD_WAIT: begin
            state_nxt = ST_RESPOND;                         // load data registered with the ack
         end
         ST_RESPOND: begin
            state_nxt = ST_IDLE;                            // master sees ack, request not resampled
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   assign ack_nxt = (state_nxt == ST_RESPOND);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= ST_IDLE;
         wb_ack <= 1'b0;
      end else begin
         state  <= state_nxt;
         wb_ack <= ack_nxt;                                 // single cycle, one per transfer
      end
   end

endmodule

`default_nettype wire

// File: hdl/dccm_ctl.sv
// dccm controller top: wishbone port, access stage, store buffer, data memory and load aligner
`timescale 1ns/1ns
`default_nettype none

module dccm_ctl
   import dccm_pkg::*;
#(
   parameter int RAM_WORDS   = 1024,
   parameter int STBUF_DEPTH = 4
)(
   input  logic       clk,
   input  logic       rst_n,

   // wishbone classic slave
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  word_addr_t wb_adr,
   input  byteen_t    wb_sel,
   input  data_t      wb_dat_w,
   output data_t      wb_dat_r,
   output logic       wb_ack
);

   lsu_req_t req;
   logic     push;
   logic     rd_req;
   logic     stbuf_ready;
   fwd_t     fwd;
   ram_req_t ram_req;
   data_t    rdata;

   dccm_access u_access (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_sel      (wb_sel),
      .wb_dat_w    (wb_dat_w),
      .wb_ack      (wb_ack),
      .stbuf_ready (stbuf_ready),
      .push        (push),
      .rd_req      (rd_req),
      .req         (req)
   );

   dccm_stbuf #(
      .STBUF_DEPTH (STBUF_DEPTH)
   ) u_stbuf (
      .clk     (clk),
      .rst_n   (rst_n),
      .push    (push),
      .rd_req  (rd_req),
      .req     (req),
      .wb_cyc  (wb_cyc),
      .ready   (stbuf_ready),
      .fwd     (fwd),
      .ram_req (ram_req)
   );

   dccm_ram #(
      .RAM_WORDS (RAM_WORDS)
   ) u_ram (
      .clk     (clk),
      .ram_req (ram_req),
      .rdata   (rdata)
   );

   dccm_load_align u_load_align (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_req   (rd_req),
      .req      (req),
      .fwd      (fwd),
      .rdata    (rdata),
      .wb_dat_r (wb_dat_r)
   );

endmodule

`default_nettype wire

// File: hdl/dccm_load_align.sv
// dccm load aligner: forward capture, byte merge over memory data, right justify and zero fill
`timescale 1ns/1ns
`default_nettype none

module dccm_load_align
   import dccm_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     rd_req,
   input  lsu_req_t req,
   input  fwd_t     fwd,
   input  data_t    rdata,
   output data_t    wb_dat_r
);

   fwd_t       fwd_q;
   byteen_t    sel_q;
   logic [1:0] offset_q;
   logic       rd_pend;
   data_t      merged;
   data_t      shifted;
   byteen_t    keep;
   data_t      result;

   // --------------------
   // capture at read time
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= rd_req;                                 // memory data valid this cycle
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req) begin
         fwd_q    <= fwd;                                   // buffer state at the read
         sel_q    <= req.byteen;
         offset_q <= req.offset;
      end
      if (rd_pend) begin
         wb_dat_r <= result;
      end
   end

   // --------------------
   // merge and align
   // --------------------
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         merged[8*b +: 8] = fwd_q.byteen[b] ? fwd_q.data[8*b +: 8] : rdata[8*b +: 8];
      end
      shifted = merged >> {offset_q, 3'b000};               // lowest selected byte to 7:0
      keep    = sel_q >> offset_q;                          // access size as low byte mask
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         result[8*b +: 8] = keep[b] ? shifted[8*b +: 8] : 8'h00;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dccm_pkg.sv
// dccm package: data and address widths, access request, store entry, forward and memory port structs
`default_nettype none

package dccm_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int DATA_W         = 32;
   localparam int BYTES_PER_WORD = DATA_W / 8;
   localparam int WORD_ADDR_W    = 14;            // byte address is two bits wider

   typedef logic [BYTES_PER_WORD-1:0] byteen_t;
   typedef logic [WORD_ADDR_W-1:0]    word_addr_t;
   typedef logic [DATA_W-1:0]         data_t;

   // --------------------
   // pipeline structs
   // --------------------

   // one accepted bus access, built by the access stage
   typedef struct packed {
      logic       is_store;
      word_addr_t word_addr;
      byteen_t    byteen;
      logic [1:0] offset;                         // lowest selected byte lane
      data_t      wdata;                          // store data, already on its byte lanes
   } lsu_req_t;

   // one store waiting in the buffer
   typedef struct packed {
      word_addr_t word_addr;
      byteen_t    byteen;
      data_t      data;
   } stbuf_entry_t;

   // bytes the store buffer still owns for one word
   typedef struct packed {
      byteen_t byteen;
      data_t   data;
   } fwd_t;

   // single memory port cycle, read or commit write
   typedef struct packed {
      logic       en;
      logic       we;
      word_addr_t word_addr;
      byteen_t    byteen;
      data_t      wdata;
   } ram_req_t;

endpackage

`default_nettype wire

// File: hdl/dccm_ram.sv
// dccm data memory: single ported word array, byte write enables, registered read
`timescale 1ns/1ns
`default_nettype none

module dccm_ram
   import dccm_pkg::*;
#(
   parameter int RAM_WORDS = 1024
)(
   input  logic     clk,
   input  ram_req_t ram_req,
   output data_t    rdata
);

   localparam int RAM_AW = $clog2(RAM_WORDS);

   data_t             mem [RAM_WORDS];
   logic [RAM_AW-1:0] addr;

   assign addr = ram_req.word_addr[RAM_AW-1:0];             // upper word address bits alias

   // --------------------
   // memory port
   // --------------------
   always_ff @(posedge clk) begin
      if (ram_req.en) begin
         if (ram_req.we) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               if (ram_req.byteen[b]) begin
                  mem[addr][8*b +: 8] <= ram_req.wdata[8*b +: 8];
               end
            end
         end else begin
            rdata <= mem[addr];                             // held until the next read
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/dccm_stbuf.sv
// dccm store buffer: store FIFO, memory port arbitration between load read and commit, forwarding
`timescale 1ns/1ns
`default_nettype none

module dccm_stbuf
   import dccm_pkg::*;
#(
   parameter int STBUF_DEPTH = 4
)(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  logic     rd_req,
   input  lsu_req_t req,
   input  logic     wb_cyc,
   output logic     ready,
   output fwd_t     fwd,
   output ram_req_t ram_req
);

   localparam int PTR_W = $clog2(STBUF_DEPTH);

   stbuf_entry_t     entries [STBUF_DEPTH];
   stbuf_entry_t     head_entry;
   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] tail;
   logic [PTR_W:0]   count;
   logic [PTR_W-1:0] scan_idx;
   logic             empty;
   logic             full;
   logic             commit;

   // --------------------
   // FIFO storage
   // --------------------
   always_ff @(posedge clk) begin
      if (push) begin
         entries[tail].word_addr <= req.word_addr;
         entries[tail].byteen    <= req.byteen;
         entries[tail].data      <= req.wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;                            // wraps, depth is a power of two
         end
         if (commit) begin
            head <= head + 1'b1;
         end
         case ({push, commit})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty = (count == '0);
   assign full  = count[PTR_W];                             // count tops out at STBUF_DEPTH
   assign ready = ~full;

   // --------------------
   // commit arbitration
   // --------------------
   // a load always owns the port; a full buffer drains even during a bus cycle
   assign commit     = ~rd_req & ~empty & (~wb_cyc | full);
   assign head_entry = entries[head];

   always_comb begin
      ram_req.en        = rd_req | commit;
      ram_req.we        = commit;
      ram_req.word_addr = rd_req ? req.word_addr : head_entry.word_addr;
      ram_req.byteen    = head_entry.byteen;
      ram_req.wdata     = head_entry.data;
   end

   // --------------------
   // forwarding lookup
   // --------------------
   // oldest to newest, so a later store to the same byte overwrites
   always_comb begin
      fwd.byteen = '0;
      fwd.data   = '0;
      scan_idx   = head;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         scan_idx = head + PTR_W'(i);
         if ((i < int'(count)) && (entries[scan_idx].word_addr == req.word_addr)) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               if (entries[scan_idx].byteen[b]) begin
                  fwd.data[8*b +: 8] = entries[scan_idx].data[8*b +: 8];
               end
            end
            fwd.byteen = fwd.byteen | entries[scan_idx].byteen;
         end
      end
   end

endmodule

`default_nettype wire

// File: verif/tb_dccm_ctl.sv
// testbench for the dccm controller with clock and reset, test table, wishbone master, byte reference model and checks
`timescale 1ns/1ns
`default_nettype none

module tb_dccm_ctl
   import dccm_pkg::*;
();

   localparam int RAM_WORDS    = 1024;
   localparam int STBUF_DEPTH  = 4;
   localparam int RESET_CYCLES = 10;
   localparam int IDLE_CYCLES  = 5;
   localparam int ENTRY_CYCLES = 40;

   typedef struct {
      logic       is_store;
      logic       hold;                                     // keep wb_cyc high after this transfer
      logic       check;
      logic       rnd;                                      // replace wdata with lfsr data
      word_addr_t adr;
      byteen_t    sel;
      data_t      wdata;
   } entry_t;

   logic       clk;
   logic       rst_n;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   word_addr_t wb_adr;
   byteen_t    wb_sel;
   data_t      wb_dat_w;
   data_t      wb_dat_r;
   logic       wb_ack;

   entry_t      tests[$];
   logic [7:0]  ref_bytes [RAM_WORDS*BYTES_PER_WORD];
   logic [31:0] lfsr_state;
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;

   dccm_ctl #(
      .RAM_WORDS   (RAM_WORDS),
      .STBUF_DEPTH (STBUF_DEPTH)
   ) u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_sel   (wb_sel),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   always #20 clk = ~clk;

   // --------------------
   // helpers
   // --------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);     // taps 32 22 2 1
   endfunction

   task automatic random_word(output data_t w);
      for (int i = 0; i < DATA_W; i++) begin
         w[i]       = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // selected bytes packed from the bottom and the rest zero
   function automatic data_t expected_load(input word_addr_t adr, input byteen_t sel);
      data_t val;
      int    pos;
      val = '0;
      pos = 0;
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         if (sel[b]) begin
            val[8*pos +: 8] = ref_bytes[int'(adr)*BYTES_PER_WORD + b];
            pos++;
         end
      end
      return val;
   endfunction

   task automatic compare(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic add_test(input logic st, input logic hold, input logic chk, input logic rnd,
                           input word_addr_t adr, input byteen_t sel, input data_t wdata);
      tests.push_back('{st, hold, chk, rnd, adr, sel, wdata});
   endtask

   // one wishbone classic transfer driven on the falling edge
   task automatic bus_transfer(input entry_t e, output data_t rdata);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = e.is_store;
      wb_adr   = e.adr;
      wb_sel   = e.sel;
      wb_dat_w = e.wdata;
      do @(negedge clk); while (wb_ack !== 1'b1);
      rdata  = wb_dat_r;
      wb_stb = 1'b0;
      wb_cyc = e.hold;
      @(negedge clk);
      compare("ack lasts one cycle", data_t'(wb_ack), '0);
   endtask

   // --------------------
   // test table
   // --------------------
   task automatic build_tests();
      add_test(0, 0, 0, 0, 14'h123, 4'hF, '0);              // unwritten word so only the ack counts
      add_test(1, 0, 1, 0, 14'h010, 4'hF, 32'hdead_beef);
      add_test(0, 0, 1, 0, 14'h010, 4'hF, '0);
      add_test(1, 0, 1, 0, 14'h020, 4'hF, 32'h1122_3344);
      add_test(1, 0, 1, 0, 14'h020, 4'h2, 32'h0000_aa00);
      add_test(1, 0, 1, 0, 14'h020, 4'hC, 32'hbbcc_0000);
      add_test(0, 0, 1, 0, 14'h020, 4'hF, '0);
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         add_test(0, 0, 1, 0, 14'h020, byteen_t'(1 << b), '0);
      end
      add_test(0, 0, 1, 0, 14'h020, 4'h3, '0);
      add_test(0, 0, 1, 0, 14'h020, 4'hC, '0);
      for (int i = 0; i < 6; i++) begin
         add_test(1, 1, 1, 1, word_addr_t'(14'h030 + i), 4'hF, '0);   // fills the buffer
      end
      for (int i = 0; i < 6; i++) begin
         add_test(0, (i < 5), 1, 0, word_addr_t'(14'h030 + i), 4'hF, '0);
      end
      add_test(1, 0, 1, 1, 14'h010, 4'hF, '0);
      add_test(0, 0, 1, 0, 14'h010, 4'hF, '0);
      add_test(1, 1, 1, 1, 14'h020, 4'h4, '0);
      add_test(0, 1, 1, 0, 14'h010, 4'h3, '0);
      add_test(1, 1, 1, 1, 14'h030, 4'h3, '0);
      add_test(0, 0, 1, 0, 14'h020, 4'hC, '0);
      add_test(1, 0, 1, 1, 14'h031, 4'h8, '0);
      add_test(1, 0, 1, 1, 14'h031, 4'h1, '0);
      add_test(0, 0, 1, 0, 14'h031, 4'hF, '0);
      add_test(0, 0, 1, 0, 14'h030, 4'hF, '0);
      add_test(1, 0, 1, 1, 14'h010, 4'hC, '0);
      add_test(0, 0, 1, 0, 14'h010, 4'h4, '0);
   endtask

   // --------------------
   // watchdog
   // --------------------
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      entry_t e;
      data_t  got;
      int     err_before;
      clk         = 1'b0;
      rst_n       = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_sel      = '0;
      wb_dat_w    = '0;
      lfsr_state  = 32'd43;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      build_tests();
      cycle_limit = ENTRY_CYCLES * tests.size() + RESET_CYCLES + IDLE_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      repeat (IDLE_CYCLES) begin
         @(negedge clk);
         compare("ack with no bus cycle", data_t'(wb_ack), '0);
      end
      for (int t = 0; t < tests.size(); t++) begin
         e          = tests[t];
         err_before = errors;
         if (e.rnd) begin
            random_word(e.wdata);
         end
         bus_transfer(e, got);
         if (e.is_store) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               if (e.sel[b]) begin
                  ref_bytes[int'(e.adr)*BYTES_PER_WORD + b] = e.wdata[8*b +: 8];
               end
            end
         end else if (e.check) begin
            compare($sformatf("load %h sel %b", e.adr, e.sel), got, expected_load(e.adr, e.sel));
         end
         $display("test %0d %s adr %h sel %b: %s", t, e.is_store ? "store" : "load",
                  e.adr, e.sel, (errors == err_before) ? "ok" : "failed");
      end
      repeat (4) @(negedge clk);
      $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
